// File: verilog/lane_cfg_pkg.sv
/*
 * Lane configuration
 * Element, register and register-file sizes of the single vector lane
 */
package lane_cfg_pkg;

  localparam int unsigned ElemWidth    = 16;
  localparam int unsigned NrElems      = 4;
  localparam int unsigned NrVRegs      = 8;
  localparam int unsigned VRegIdxWidth = 3;
  localparam int unsigned ElemIdxWidth = 2;
  localparam int unsigned VAddrWidth   = VRegIdxWidth + ElemIdxWidth;

  // Two banks split by element parity, two operand ports plus the probe
  localparam int unsigned NrBanks      = 2;
  localparam int unsigned BankDepth    = NrVRegs * NrElems / NrBanks;
  localparam int unsigned NrRdPorts    = 3;

  typedef logic [ElemWidth-1:0]    elem_t;
  typedef logic [VRegIdxWidth-1:0] vreg_idx_t;
  typedef logic [ElemIdxWidth-1:0] elem_idx_t;
  // Register number in the upper bits, element number in the lower bits
  typedef logic [VAddrWidth-1:0]   vaddr_t;

endpackage

// File: verilog/lane_op_pkg.sv
/*
 * Lane operation types
 * Operation word, instruction request, element token and write-back types
 */
package lane_op_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_MIN = 3'd5,
    ALU_MAX = 3'd6
  } alu_op_e;

  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_e;

  // Swap exchanges the two operands before the operation
  typedef struct packed {
    logic    swap;
    alu_op_e op;
  } alu_view_t;

  typedef struct packed {
    logic high;  // upper half of the 32-bit product
    logic sgn;
    logic neg;
    logic rsvd;
  } mul_view_t;

  // Same four bits, decoded differently by each unit
  typedef union packed {
    alu_view_t alu;
    mul_view_t mul;
  } op_word_u;

  typedef struct packed {
    fu_e                     fu;
    op_word_u                op;
    lane_cfg_pkg::vreg_idx_t vd;
    lane_cfg_pkg::vreg_idx_t vs1;
    lane_cfg_pkg::vreg_idx_t vs2;
    lane_cfg_pkg::elem_idx_t vl;   // element count minus one
  } lane_req_t;

  typedef struct packed {
    op_word_u                op;
    lane_cfg_pkg::vreg_idx_t vd;
    lane_cfg_pkg::elem_idx_t idx;
    logic                    last;
    fu_e                     fu;
  } elem_tok_t;

  typedef struct packed {
    lane_cfg_pkg::vaddr_t addr;
    lane_cfg_pkg::elem_t  data;
    logic                 last;
  } fu_result_t;

  typedef struct packed {
    logic                 en;
    lane_cfg_pkg::vaddr_t addr;
    lane_cfg_pkg::elem_t  data;
  } vrf_wr_t;

  typedef struct packed {
    lane_cfg_pkg::vaddr_t addr;
    lane_cfg_pkg::elem_t  data;
  } ld_req_t;

endpackage

// File: verilog/lane_vrf.sv
/*
 * Lane vector register file
 * Two banks by element parity, three synchronous read ports, one write port
 */
`timescale 1ns/10ps

module lane_vrf (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  lane_cfg_pkg::vaddr_t rd_addr_a_i,
  input  lane_cfg_pkg::vaddr_t rd_addr_b_i,
  input  lane_cfg_pkg::vaddr_t probe_addr_i,
  input  lane_op_pkg::vrf_wr_t wr_i,
  output lane_cfg_pkg::elem_t  rd_data_a_o,
  output lane_cfg_pkg::elem_t  rd_data_b_o,
  output lane_cfg_pkg::elem_t  probe_data_o
);

  lane_cfg_pkg::vaddr_t [lane_cfg_pkg::NrRdPorts-1:0] rd_addr;
  logic                 [lane_cfg_pkg::NrRdPorts-1:0] bank_sel_q;

  lane_cfg_pkg::elem_t [lane_cfg_pkg::NrRdPorts-1:0] bank_rd_q [lane_cfg_pkg::NrBanks];
  lane_cfg_pkg::elem_t mem_q [lane_cfg_pkg::NrBanks][lane_cfg_pkg::BankDepth];

  // Port order: operand a, operand b, probe
  assign rd_addr = {probe_addr_i, rd_addr_b_i, rd_addr_a_i};

  // Every bank reads its row for every port, old data on a read of the written word
  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      mem_q[wr_i.addr[0]][wr_i.addr[lane_cfg_pkg::VAddrWidth-1:1]] <= wr_i.data;
    end
    for (int b = 0; b < lane_cfg_pkg::NrBanks; b++) begin
      for (int p = 0; p < lane_cfg_pkg::NrRdPorts; p++) begin
        bank_rd_q[b][p] <= mem_q[b][rd_addr[p][lane_cfg_pkg::VAddrWidth-1:1]];
      end
    end
  end

  // Parity of each read address picks the bank one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_sel_q <= '0;
    end else begin
      for (int p = 0; p < lane_cfg_pkg::NrRdPorts; p++) begin
        bank_sel_q[p] <= rd_addr[p][0];
      end
    end
  end

  assign rd_data_a_o  = bank_rd_q[bank_sel_q[0]][0];
  assign rd_data_b_o  = bank_rd_q[bank_sel_q[1]][1];
  assign probe_data_o = bank_rd_q[bank_sel_q[2]][2];

endmodule

// File: verilog/lane_sequencer.sv
/*
 * Lane sequencer
 * Accepts one instruction at a time, checks the busy scoreboard and
 * issues the elements one per cycle to the ALU or the multiplier
 */
`timescale 1ns/10ps

module lane_sequencer (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_op_pkg::lane_req_t  req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output lane_cfg_pkg::vaddr_t    rd_addr_a_o,
  output lane_cfg_pkg::vaddr_t    rd_addr_b_o,
  output lane_op_pkg::elem_tok_t  tok_o,
  output logic                    alu_issue_o,
  output logic                    mul_issue_o,
  input  logic                    alu_ready_i,
  input  logic                    mul_ready_i,
  input  logic                    clr_valid_i,
  input  lane_cfg_pkg::vreg_idx_t clr_vreg_i
);

  lane_op_pkg::lane_req_t           req_q;
  lane_cfg_pkg::elem_idx_t          cnt_q;
  logic                             busy_q;
  logic [lane_cfg_pkg::NrVRegs-1:0] sb_q;
  logic [lane_cfg_pkg::NrVRegs-1:0] sb_d;
  lane_op_pkg::elem_tok_t           tok_q;
  logic                             tok_valid_q;
  lane_cfg_pkg::vaddr_t             rd_a_q;
  lane_cfg_pkg::vaddr_t             rd_b_q;

  logic hazard;
  logic accept;
  logic tok_ready;
  logic tgt_ready;
  logic stall;
  logic issue;
  logic last;

  //////////////////////////////////////////////////////////////////////////////
  // Accept and scoreboard
  //////////////////////////////////////////////////////////////////////////////

  // Any register of the new instruction still waiting for its last write
  assign hazard      = sb_q[req_i.vs1] | sb_q[req_i.vs2] | sb_q[req_i.vd];
  assign req_ready_o = ~busy_q & ~hazard;
  assign accept      = req_valid_i & req_ready_o;

  always_comb begin
    sb_d = sb_q;
    if (clr_valid_i) begin
      sb_d[clr_vreg_i] = 1'b0;
    end
    if (accept) begin
      sb_d[req_i.vd] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Element issue
  //////////////////////////////////////////////////////////////////////////////

  // A presented token its unit cannot take stays put
  assign tok_ready = (tok_q.fu == lane_op_pkg::FU_MUL) ? mul_ready_i : alu_ready_i;
  assign tgt_ready = (req_q.fu == lane_op_pkg::FU_MUL) ? mul_ready_i : alu_ready_i;
  assign stall     = tok_valid_q & ~tok_ready;
  assign issue     = busy_q & tgt_ready & ~stall;
  assign last      = (cnt_q == req_q.vl);

  // During a stall the held token's operands are read again
  assign rd_addr_a_o = stall ? rd_a_q : {req_q.vs1, cnt_q};
  assign rd_addr_b_o = stall ? rd_b_q : {req_q.vs2, cnt_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      cnt_q       <= '0;
      sb_q        <= '0;
      tok_valid_q <= 1'b0;
    end else begin
      sb_q <= sb_d;
      if (accept) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (issue) begin
        busy_q <= ~last;
        cnt_q  <= last ? '0 : cnt_q + lane_cfg_pkg::elem_idx_t'(1);
      end
      if (!stall) begin
        tok_valid_q <= issue;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (!stall) begin
      tok_q <= '{op: req_q.op, vd: req_q.vd, idx: cnt_q, last: last, fu: req_q.fu};
    end
    rd_a_q <= rd_addr_a_o;
    rd_b_q <= rd_addr_b_o;
  end

  // Token lines up with the read data of the cycle before
  assign tok_o       = tok_q;
  assign alu_issue_o = tok_valid_q & (tok_q.fu == lane_op_pkg::FU_ALU) & alu_ready_i;
  assign mul_issue_o = tok_valid_q & (tok_q.fu == lane_op_pkg::FU_MUL) & mul_ready_i;

endmodule

// File: verilog/lane_alu.sv
/*
 * Lane ALU
 * One-stage integer unit, result held until write-back grants it
 */
`timescale 1ns/10ps

module lane_alu (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_op_pkg::elem_tok_t  tok_i,
  input  logic                    valid_i,
  input  lane_cfg_pkg::elem_t     opa_i,
  input  lane_cfg_pkg::elem_t     opb_i,
  output logic                    ready_o,
  output lane_op_pkg::fu_result_t res_o,
  output logic                    res_valid_o,
  input  logic                    res_gnt_i
);

  lane_cfg_pkg::elem_t     a;
  lane_cfg_pkg::elem_t     b;
  lane_cfg_pkg::elem_t     y;
  lane_op_pkg::fu_result_t res_q;
  logic                    res_valid_q;

  assign a = tok_i.op.alu.swap ? opb_i : opa_i;
  assign b = tok_i.op.alu.swap ? opa_i : opb_i;

  // Wraparound arithmetic, signed compare for min and max
  always_comb begin
    case (tok_i.op.alu.op)
      lane_op_pkg::ALU_ADD: y = a + b;
      lane_op_pkg::ALU_SUB: y = a - b;
      lane_op_pkg::ALU_AND: y = a & b;
      lane_op_pkg::ALU_OR:  y = a | b;
      lane_op_pkg::ALU_XOR: y = a ^ b;
      lane_op_pkg::ALU_MIN: y = ($signed(a) < $signed(b)) ? a : b;
      lane_op_pkg::ALU_MAX: y = ($signed(a) > $signed(b)) ? a : b;
      default:              y = a;
    endcase
  end

  // Free slot, or the held result leaves this cycle
  assign ready_o = ~res_valid_q | res_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (ready_o) begin
      res_valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      res_q <= '{addr: {tok_i.vd, tok_i.idx}, data: y, last: tok_i.last};
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

// File: verilog/lane_mul.sv
/*
 * Lane multiplier
 * Two stages: 32-bit product, then optional negation and half select
 */
`timescale 1ns/10ps

module lane_mul (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_op_pkg::elem_tok_t  tok_i,
  input  logic                    valid_i,
  input  lane_cfg_pkg::elem_t     opa_i,
  input  lane_cfg_pkg::elem_t     opb_i,
  output logic                    ready_o,
  output lane_op_pkg::fu_result_t res_o,
  output logic                    res_valid_o,
  input  logic                    res_gnt_i
);

  logic [2*lane_cfg_pkg::ElemWidth-1:0] ext_a;
  logic [2*lane_cfg_pkg::ElemWidth-1:0] ext_b;
  logic [2*lane_cfg_pkg::ElemWidth-1:0] prod_q;
  logic [2*lane_cfg_pkg::ElemWidth-1:0] prod_n;
  lane_op_pkg::elem_tok_t               s1_tok_q;
  logic                                 s1_valid_q;
  lane_op_pkg::fu_result_t              res_q;
  logic                                 res_valid_q;
  logic                                 advance;

  // Sign extension gives the signed product in the low 32 bits
  assign ext_a = {{lane_cfg_pkg::ElemWidth{tok_i.op.mul.sgn & opa_i[lane_cfg_pkg::ElemWidth-1]}},
                  opa_i};
  assign ext_b = {{lane_cfg_pkg::ElemWidth{tok_i.op.mul.sgn & opb_i[lane_cfg_pkg::ElemWidth-1]}},
                  opb_i};

  // Whole pipe freezes on an ungranted result
  assign advance = ~res_valid_q | res_gnt_i;
  assign ready_o = advance;

  assign prod_n = s1_tok_q.op.mul.neg ? -prod_q : prod_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q  <= valid_i;
      res_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance && valid_i) begin
      prod_q   <= ext_a * ext_b;
      s1_tok_q <= tok_i;
    end
    if (advance && s1_valid_q) begin
      res_q.addr <= {s1_tok_q.vd, s1_tok_q.idx};
      res_q.data <= s1_tok_q.op.mul.high ? prod_n[2*lane_cfg_pkg::ElemWidth-1:lane_cfg_pkg::ElemWidth]
                                         : prod_n[lane_cfg_pkg::ElemWidth-1:0];
      res_q.last <= s1_tok_q.last;
    end
  end

  assign res_o       = res_q;
  assign res_valid_o = res_valid_q;

endmodule

// File: verilog/lane_writeback.sv
/*
 * Lane write-back
 * Fixed priority onto the write port: multiplier, ALU, then loads
 */
`timescale 1ns/10ps

module lane_writeback (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lane_op_pkg::fu_result_t alu_res_i,
  input  logic                    alu_valid_i,
  output logic                    alu_gnt_o,
  input  lane_op_pkg::fu_result_t mul_res_i,
  input  logic                    mul_valid_i,
  output logic                    mul_gnt_o,
  input  lane_op_pkg::ld_req_t    ld_i,
  input  logic                    ld_valid_i,
  output logic                    ld_ready_o,
  output lane_op_pkg::vrf_wr_t    wr_o,
  output logic                    clr_valid_o,
  output lane_cfg_pkg::vreg_idx_t clr_vreg_o,
  output logic                    alu_done_o,
  output logic                    mul_done_o
);

  logic alu_last;
  logic mul_last;
  logic alu_done_q;
  logic mul_done_q;

  assign mul_gnt_o  = mul_valid_i;
  assign alu_gnt_o  = alu_valid_i & ~mul_valid_i;
  assign ld_ready_o = ld_valid_i & ~mul_valid_i & ~alu_valid_i;

  always_comb begin
    wr_o.en = mul_valid_i | alu_valid_i | ld_valid_i;
    if (mul_valid_i) begin
      wr_o.addr = mul_res_i.addr;
      wr_o.data = mul_res_i.data;
    end else if (alu_valid_i) begin
      wr_o.addr = alu_res_i.addr;
      wr_o.data = alu_res_i.data;
    end else begin
      wr_o.addr = ld_i.addr;
      wr_o.data = ld_i.data;
    end
  end

  // Last element written frees its destination register
  assign mul_last    = mul_gnt_o & mul_res_i.last;
  assign alu_last    = alu_gnt_o & alu_res_i.last;
  assign clr_valid_o = mul_last | alu_last;
  assign clr_vreg_o  = wr_o.addr[lane_cfg_pkg::ElemIdxWidth +: lane_cfg_pkg::VRegIdxWidth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_done_q <= 1'b0;
      mul_done_q <= 1'b0;
    end else begin
      alu_done_q <= alu_last;
      mul_done_q <= mul_last;
    end
  end

  assign alu_done_o = alu_done_q;
  assign mul_done_o = mul_done_q;

endmodule

// File: verilog/lane_top.sv
/*
 * Vector lane top level
 * Register file, sequencer, ALU and multiplier side by side, write-back
 */
`timescale 1ns/10ps

module lane_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  lane_op_pkg::lane_req_t req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  lane_op_pkg::ld_req_t   ld_i,
  input  logic                   ld_valid_i,
  output logic                   ld_ready_o,
  input  lane_cfg_pkg::vaddr_t   probe_addr_i,
  output lane_cfg_pkg::elem_t    probe_data_o,
  output logic                   alu_done_o,
  output logic                   mul_done_o
);

  lane_cfg_pkg::vaddr_t    rd_addr_a, rd_addr_b;
  lane_cfg_pkg::elem_t     rd_data_a, rd_data_b;
  lane_op_pkg::elem_tok_t  tok;
  logic                    alu_issue, mul_issue;
  logic                    alu_ready, mul_ready;
  lane_op_pkg::fu_result_t alu_res, mul_res;
  logic                    alu_res_valid, mul_res_valid;
  logic                    alu_gnt, mul_gnt;
  lane_op_pkg::vrf_wr_t    vrf_wr;
  logic                    clr_valid;
  lane_cfg_pkg::vreg_idx_t clr_vreg;

  //////////////////////////////////////////////////////////////////////////////
  // Register file and sequencer
  //////////////////////////////////////////////////////////////////////////////

  lane_vrf i_lane_vrf (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .rd_addr_a_i (rd_addr_a   ),
    .rd_addr_b_i (rd_addr_b   ),
    .probe_addr_i(probe_addr_i),
    .wr_i        (vrf_wr      ),
    .rd_data_a_o (rd_data_a   ),
    .rd_data_b_o (rd_data_b   ),
    .probe_data_o(probe_data_o)
  );

  lane_sequencer i_lane_sequencer (
    .clk_i      (clk_i      ),
    .rst_ni     (rst_ni     ),
    .req_i      (req_i      ),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .rd_addr_a_o(rd_addr_a  ),
    .rd_addr_b_o(rd_addr_b  ),
    .tok_o      (tok        ),
    .alu_issue_o(alu_issue  ),
    .mul_issue_o(mul_issue  ),
    .alu_ready_i(alu_ready  ),
    .mul_ready_i(mul_ready  ),
    .clr_valid_i(clr_valid  ),
    .clr_vreg_i (clr_vreg   )
  );

  //////////////////////////////////////////////////////////////////////////////
  // Functional units and write-back
  //////////////////////////////////////////////////////////////////////////////

  // Both units see the same token and operands, the issue strobe selects one
  lane_alu i_lane_alu (
    .clk_i      (clk_i        ),
    .rst_ni     (rst_ni       ),
    .tok_i      (tok          ),
    .valid_i    (alu_issue    ),
    .opa_i      (rd_data_a    ),
    .opb_i      (rd_data_b    ),
    .ready_o    (alu_ready    ),
    .res_o      (alu_res      ),
    .res_valid_o(alu_res_valid),
    .res_gnt_i  (alu_gnt      )
  );

  lane_mul i_lane_mul (
    .clk_i      (clk_i        ),
    .rst_ni     (rst_ni       ),
    .tok_i      (tok          ),
    .valid_i    (mul_issue    ),
    .opa_i      (rd_data_a    ),
    .opb_i      (rd_data_b    ),
    .ready_o    (mul_ready    ),
    .res_o      (mul_res      ),
    .res_valid_o(mul_res_valid),
    .res_gnt_i  (mul_gnt      )
  );

  lane_writeback i_lane_writeback (
    .clk_i      (clk_i        ),
    .rst_ni     (rst_ni       ),
    .alu_res_i  (alu_res      ),
    .alu_valid_i(alu_res_valid),
    .alu_gnt_o  (alu_gnt      ),
    .mul_res_i  (mul_res      ),
    .mul_valid_i(mul_res_valid),
    .mul_gnt_o  (mul_gnt      ),
    .ld_i       (ld_i         ),
    .ld_valid_i (ld_valid_i   ),
    .ld_ready_o (ld_ready_o   ),
    .wr_o       (vrf_wr       ),
    .clr_valid_o(clr_valid    ),
    .clr_vreg_o (clr_vreg     ),
    .alu_done_o (alu_done_o   ),
    .mul_done_o (mul_done_o   )
  );

endmodule

// File: tests/lane_props.sv
/*
 * Lane properties
 * Handshake, done pulse and reset rules on the lane top level
 */
`timescale 1ns/10ps

module lane_props (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 req_valid_i,
  input logic                 req_ready_i,
  input logic                 ld_valid_i,
  input logic                 ld_ready_i,
  input logic                 alu_done_i,
  input logic                 mul_done_i,
  input lane_op_pkg::vrf_wr_t wr_i
);

  // Load port only answers a pending load
  ld_ready_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ld_ready_i |-> ld_valid_i
  ) else $error("ld_ready_o high without ld_valid_i");

  done_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(alu_done_i && mul_done_i)
  ) else $error("alu_done_o and mul_done_o high together");

  // Checked during reset itself
  no_write_in_reset: assert property (
    @(posedge clk_i) !rst_ni |-> !wr_i.en
  ) else $error("register file write while in reset");

  // Sequencer holds the accepted instruction
  busy_after_accept: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (req_valid_i && req_ready_i) |=> !req_ready_i
  ) else $error("req_ready_o high right after an accepted request");

endmodule

bind lane_top lane_props i_lane_props (
  .clk_i      (clk_i      ),
  .rst_ni     (rst_ni     ),
  .req_valid_i(req_valid_i),
  .req_ready_i(req_ready_o),
  .ld_valid_i (ld_valid_i ),
  .ld_ready_i (ld_ready_o ),
  .alu_done_i (alu_done_o ),
  .mul_done_i (mul_done_o ),
  .wr_i       (vrf_wr     )
);

// File: tests/tb_lane.sv
/*
 * Lane testbench
 * Runs the command patterns against the lane top level, checks the
 * probe reads and counts the done pulses
 */
`timescale 1ns/10ps

module tb_lane;

  logic                   clk_i;
  logic                   rst_ni;
  lane_op_pkg::lane_req_t req_i;
  logic                   req_valid_i;
  logic                   req_ready_o;
  lane_op_pkg::ld_req_t   ld_i;
  logic                   ld_valid_i;
  logic                   ld_ready_o;
  lane_cfg_pkg::vaddr_t   probe_addr_i;
  lane_cfg_pkg::elem_t    probe_data_o;
  logic                   alu_done_o;
  logic                   mul_done_o;

  logic [31:0] pat_mem [128];
  int unsigned nr_lines;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 0;
  int unsigned err_cnt     = 0;
  int unsigned err_base    = 0;
  int unsigned tests_pass  = 0;
  int unsigned tests_fail  = 0;
  int unsigned alu_total   = 0;
  int unsigned mul_total   = 0;
  int unsigned alu_expect  = 0;
  int unsigned mul_expect  = 0;

  lane_top i_lane_top (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .req_i       (req_i       ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .ld_i        (ld_i        ),
    .ld_valid_i  (ld_valid_i  ),
    .ld_ready_o  (ld_ready_o  ),
    .probe_addr_i(probe_addr_i),
    .probe_data_o(probe_data_o),
    .alu_done_o  (alu_done_o  ),
    .mul_done_o  (mul_done_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("Finished with errors");
      $finish;
    end
  end

  // Done outputs are registered, stable at the falling edge
  always @(negedge clk_i) begin
    if (alu_done_o) begin
      alu_total <= alu_total + 1;
    end
    if (mul_done_o) begin
      mul_total <= mul_total + 1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Commands
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_load(input logic [31:0] w);
    @(posedge clk_i);
    ld_i       <= '{addr: w[20:16], data: w[15:0]};
    ld_valid_i <= 1'b1;
    do begin
      @(negedge clk_i);
    end while (!ld_ready_o);
    @(posedge clk_i);
    ld_valid_i <= 1'b0;
  endtask

  task automatic issue_instr(input logic [31:0] w);
    lane_op_pkg::lane_req_t req;
    req.fu  = lane_op_pkg::fu_e'(w[24]);
    req.op  = w[23:20];
    req.vd  = w[18:16];
    req.vs1 = w[14:12];
    req.vs2 = w[10:8];
    req.vl  = w[5:4];
    @(posedge clk_i);
    req_i       <= req;
    req_valid_i <= 1'b1;
    // Hazard or a running instruction keeps ready low
    do begin
      @(negedge clk_i);
    end while (!req_ready_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
  endtask

  task automatic wait_done(input logic [31:0] w);
    alu_expect += 32'(w[7:4]);
    mul_expect += 32'(w[3:0]);
    while (alu_total < alu_expect || mul_total < mul_expect) begin
      @(posedge clk_i);
    end
    if (alu_total != alu_expect) begin
      $display("mismatch at %0t: alu_done_o pulses expected %0d actual %0d",
               $time, alu_expect, alu_total);
      err_cnt++;
      alu_expect = alu_total;
    end
    if (mul_total != mul_expect) begin
      $display("mismatch at %0t: mul_done_o pulses expected %0d actual %0d",
               $time, mul_expect, mul_total);
      err_cnt++;
      mul_expect = mul_total;
    end
  endtask

  // Probe data follows the address by one cycle
  task automatic probe_check(input logic [31:0] w);
    lane_cfg_pkg::elem_t expected;
    expected = w[15:0];
    @(posedge clk_i);
    probe_addr_i <= w[20:16];
    @(posedge clk_i);
    @(negedge clk_i);
    if (probe_data_o !== expected) begin
      $display("mismatch at %0t: probe_data_o at address %h expected %h actual %h",
               $time, w[20:16], expected, probe_data_o);
      err_cnt++;
    end
  endtask

  task automatic close_test(input logic [31:0] w);
    int unsigned test_errs;
    test_errs = err_cnt - err_base;
    if (test_errs == 0) begin
      $display("test %0d passed", w[7:0]);
      tests_pass++;
    end else begin
      $display("test %0d failed with %0d errors", w[7:0], test_errs);
      tests_fail++;
    end
    err_base = err_cnt;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    ld_i         = '0;
    ld_valid_i   = 1'b0;
    probe_addr_i = '0;
    for (int i = 0; i < 128; i++) begin
      pat_mem[i] = '0;
    end
    $readmemh("tests/lane_patterns.txt", pat_mem);
    nr_lines = 0;
    while (nr_lines < 128 && pat_mem[nr_lines][31:28] != 4'h0) begin
      nr_lines++;
    end
    cycle_limit = 50 * nr_lines;
    if (nr_lines == 0) begin
      $display("no pattern lines were read");
      err_cnt++;
      cycle_limit = 50;
    end

    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int i = 0; i < nr_lines; i++) begin
      case (pat_mem[i][31:28])
        4'h1: drive_load(pat_mem[i]);
        4'h2: issue_instr(pat_mem[i]);
        4'h3: wait_done(pat_mem[i]);
        4'h4: probe_check(pat_mem[i]);
        4'h5: close_test(pat_mem[i]);
        default: begin
          $display("unknown command %h on pattern line %0d", pat_mem[i], i);
          err_cnt++;
        end
      endcase
    end

    // Quiet period, no late done pulse expected
    repeat (10) @(posedge clk_i);
    if (alu_total != alu_expect || mul_total != mul_expect) begin
      $display("mismatch at %0t: alu_done_o/mul_done_o pulses expected %0d/%0d actual %0d/%0d",
               $time, alu_expect, mul_expect, alu_total, mul_total);
      err_cnt++;
    end

    $display("tests passed %0d, tests failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tests/lane_patterns.txt
// Each line: command nibble, then fields. 1 0 aa dddd load, 2 f o d s t v 0 instruction,
// 3 00000 a m wait for done pulses, 4 0 aa dddd probe check, 5 00000 nn end of test
10000005
10017FFF
10028000
1003FFFE
10040003
10050002
10060001
10078001
40017FFF
40078001
50000001
20020130
20930130
20540130
20650130
20260130
20370130
30000060
400B7FFF
400CFFFE
40128000
40160001
401B8000
401E8001
20420130
30000010
40097FFD
50000002
21020130
21830130
21C40130
21650130
21E60130
21A70130
30000006
400BFFFE
400F7FFF
4012FFFF
4014FFF1
4018FFFF
401A0000
401F8000
50000003
20040130
21052230
30000011
40118001
401400E1
40150004
50000004
21060130
20076130
30000011
401C0012
401D0000
401F7FFF
50000005
20220130
21831130
101C1111
101D2222
101E3333
101F4444
30000011
400B8000
400F4001
401C1111
401F4444
50000006

// File: sim.f
verilog/lane_cfg_pkg.sv
verilog/lane_op_pkg.sv
verilog/lane_vrf.sv
verilog/lane_sequencer.sv
verilog/lane_alu.sv
verilog/lane_mul.sv
verilog/lane_writeback.sv
verilog/lane_top.sv
tests/lane_props.sv
tests/tb_lane.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_lane
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Finished with no errors
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
